//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_rv_slice
RTL_TOP    := rv_slice_top
FILELIST   := sim.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing -j 0 --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q ">>> PASS" $(LOG); then echo "simulation did not complete"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim.f
src/rv_pkg.sv
src/instr_decoder.sv
src/reg_file.sv
src/pipeline_reg_d_e.sv
src/execute_stage.sv
src/rv_slice_top.sv
testbench/tb_clk_gen.sv
testbench/tb_rv_slice.sv

//--- src/execute_stage.sv
module execute_stage
    import rv_pkg::*;
#(
    parameter int WIDTH = 32
)(
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  reg_wr_en_e_i,
    input  alu_op_e               alu_op_e_i,
    input  logic                  alu_src_e_i,
    input  logic [WIDTH-1:0]      rd_data1_e_i,
    input  logic [WIDTH-1:0]      rd_data2_e_i,
    input  logic [REG_ADDR_W-1:0] rd_addr1_e_i,
    input  logic [REG_ADDR_W-1:0] rd_addr2_e_i,
    input  logic [REG_ADDR_W-1:0] wr_addr_e_i,
    input  logic [WIDTH-1:0]      imm_ext_e_i,
    output logic                  wb_en_o,
    output logic [REG_ADDR_W-1:0] wb_addr_o,
    output logic [WIDTH-1:0]      wb_data_o
);

    localparam int SHAMT_W = $clog2(WIDTH);

    logic               fwd_a;
    logic               fwd_b;
    logic [WIDTH-1:0]   src_a;
    logic [WIDTH-1:0]   src_b;
    logic [WIDTH-1:0]   op_b;
    logic [WIDTH-1:0]   alu_res;
    logic [SHAMT_W-1:0] shamt;

    // distance-one dependency, take the result still in writeback
    assign fwd_a = wb_en_o && (wb_addr_o != '0) && (wb_addr_o == rd_addr1_e_i);
    assign fwd_b = wb_en_o && (wb_addr_o != '0) && (wb_addr_o == rd_addr2_e_i);

    assign src_a = fwd_a ? wb_data_o : rd_data1_e_i;
    assign src_b = fwd_b ? wb_data_o : rd_data2_e_i;
    assign op_b  = alu_src_e_i ? imm_ext_e_i : src_b;
    assign shamt = op_b[SHAMT_W-1:0];

    always_comb begin
        case (alu_op_e_i)
            ALU_ADD:    alu_res = src_a + op_b;
            ALU_SUB:    alu_res = src_a - op_b;
            ALU_AND:    alu_res = src_a & op_b;
            ALU_OR:     alu_res = src_a | op_b;
            ALU_XOR:    alu_res = src_a ^ op_b;
            ALU_SLL:    alu_res = src_a << shamt;
            ALU_SRL:    alu_res = src_a >> shamt;
            ALU_SRA:    alu_res = $signed(src_a) >>> shamt;
            ALU_SLT:    alu_res = WIDTH'($signed(src_a) < $signed(op_b));
            ALU_SLTU:   alu_res = WIDTH'(src_a < op_b);
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    // E/W register
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i)
            wb_en_o <= 1'b0;
        else
            wb_en_o <= reg_wr_en_e_i && (wr_addr_e_i != '0);   // x0 writes dropped here
    end

    always_ff @(posedge clk_i) begin
        wb_addr_o <= wr_addr_e_i;
        wb_data_o <= alu_res;
    end

endmodule

//--- src/instr_decoder.sv
module instr_decoder
    import rv_pkg::*;
#(
    parameter int WIDTH = 32
)(
    input  logic [31:0]           instr_i,

    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o,
    output logic [REG_ADDR_W-1:0] rd_o,
    output logic [WIDTH-1:0]      imm_ext_o,
    output alu_op_e               alu_op_o,
    output logic                  alu_src_o,   // 1 = immediate
    output logic                  reg_wr_en_o
);

    opcode_e            opcode;
    logic [2:0]         funct3;
    logic               funct7_b5;   // sub / sra select
    logic signed [31:0] imm_raw;

    // funct3 map shared by register and immediate forms
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        op = ALU_ADD;
        case (f3)
            3'b000: op = alt ? ALU_SUB : ALU_ADD;
            3'b001: op = ALU_SLL;
            3'b010: op = ALU_SLT;
            3'b011: op = ALU_SLTU;
            3'b100: op = ALU_XOR;
            3'b101: op = alt ? ALU_SRA : ALU_SRL;
            3'b110: op = ALU_OR;
            3'b111: op = ALU_AND;
            default: op = ALU_ADD;
        endcase
        return op;
    endfunction

    assign opcode    = opcode_e'(instr_i[6:0]);
    assign funct3    = instr_i[14:12];
    assign funct7_b5 = instr_i[30];

    assign rs1_o = instr_i[19:15];
    assign rs2_o = instr_i[24:20];
    assign rd_o  = instr_i[11:7];

    always_comb begin
        reg_wr_en_o = 1'b0;
        alu_src_o   = 1'b0;
        alu_op_o    = ALU_ADD;
        imm_raw     = {{20{instr_i[31]}}, instr_i[31:20]};   // I-type
        case (opcode)
            OP_REG: begin
                reg_wr_en_o = 1'b1;
                alu_op_o    = arith_op(funct3, funct7_b5);
            end
            OP_IMM: begin
                reg_wr_en_o = 1'b1;
                alu_src_o   = 1'b1;
                // bit 30 is immediate data except for srai
                alu_op_o    = arith_op(funct3, funct7_b5 && (funct3 == 3'b101));
            end
            OP_LUI: begin
                reg_wr_en_o = 1'b1;
                alu_src_o   = 1'b1;
                alu_op_o    = ALU_PASS_B;
                imm_raw     = {instr_i[31:12], 12'b0};
            end
            default: reg_wr_en_o = 1'b0;   // unsupported, no write
        endcase
    end

    assign imm_ext_o = WIDTH'(imm_raw);   // signed, so extends with bit 31

endmodule

//--- src/pipeline_reg_d_e.sv
module pipeline_reg_d_e
    import rv_pkg::*;
#(
    parameter int WIDTH = 32
)(
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  flush_i,
    input  logic                  valid_i,

    // control
    input  logic                  reg_wr_en_d_i,
    input  alu_op_e               alu_op_d_i,
    input  logic                  alu_src_d_i,

    output logic                  reg_wr_en_e_o,
    output alu_op_e               alu_op_e_o,
    output logic                  alu_src_e_o,

    // data path
    input  logic [WIDTH-1:0]      rd_data1_d_i,
    input  logic [WIDTH-1:0]      rd_data2_d_i,
    input  logic [REG_ADDR_W-1:0] rd_addr1_d_i,   // rs1
    input  logic [REG_ADDR_W-1:0] rd_addr2_d_i,   // rs2
    input  logic [REG_ADDR_W-1:0] wr_addr_d_i,    // rd
    input  logic [WIDTH-1:0]      imm_ext_d_i,

    output logic [WIDTH-1:0]      rd_data1_e_o,
    output logic [WIDTH-1:0]      rd_data2_e_o,
    output logic [REG_ADDR_W-1:0] rd_addr1_e_o,
    output logic [REG_ADDR_W-1:0] rd_addr2_e_o,
    output logic [REG_ADDR_W-1:0] wr_addr_e_o,
    output logic [WIDTH-1:0]      imm_ext_e_o
);

    // bubble on flush or empty slot
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i)
            reg_wr_en_e_o <= 1'b0;
        else if (flush_i || !valid_i)
            reg_wr_en_e_o <= 1'b0;
        else
            reg_wr_en_e_o <= reg_wr_en_d_i;
    end

    always_ff @(posedge clk_i) begin
        alu_op_e_o   <= alu_op_d_i;
        alu_src_e_o  <= alu_src_d_i;
        rd_data1_e_o <= rd_data1_d_i;
        rd_data2_e_o <= rd_data2_d_i;
        rd_addr1_e_o <= rd_addr1_d_i;
        rd_addr2_e_o <= rd_addr2_d_i;
        wr_addr_e_o  <= wr_addr_d_i;
        imm_ext_e_o  <= imm_ext_d_i;
    end

endmodule

//--- src/reg_file.sv
module reg_file
    import rv_pkg::*;
#(
    parameter int WIDTH = 32
)(
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic [REG_ADDR_W-1:0] rd_addr1_i,
    input  logic [REG_ADDR_W-1:0] rd_addr2_i,
    output logic [WIDTH-1:0]      rd_data1_o,
    output logic [WIDTH-1:0]      rd_data2_o,
    input  logic                  wr_en_i,
    input  logic [REG_ADDR_W-1:0] wr_addr_i,
    input  logic [WIDTH-1:0]      wr_data_i
);

    logic [WIDTH-1:0] regs [1:(1 << REG_ADDR_W) - 1];   // no storage for x0

    // x0 reads zero, a same-cycle write is seen at once
    function automatic logic [WIDTH-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        logic [WIDTH-1:0] data;
        if (addr == '0)
            data = '0;
        else if (wr_en_i && (wr_addr_i == addr))
            data = wr_data_i;
        else
            data = regs[addr];
        return data;
    endfunction

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < (1 << REG_ADDR_W); i++)
                regs[i] <= '0;
        end else if (wr_en_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    always_comb begin
        rd_data1_o = read_port(rd_addr1_i);
        rd_data2_o = read_port(rd_addr2_i);
    end

endmodule

//--- src/rv_pkg.sv
package rv_pkg;

    parameter int REG_ADDR_W = 5;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OP_REG = 7'b0110011,   // add, sub, and ...
        OP_IMM = 7'b0010011,   // addi, slli ...
        OP_LUI = 7'b0110111
    } opcode_e;

    // alu operations
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLL    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_SLT    = 4'd8,
        ALU_SLTU   = 4'd9,
        ALU_PASS_B = 4'd10     // lui, operand b straight through
    } alu_op_e;

endpackage

//--- src/rv_slice_top.sv
module rv_slice_top
    import rv_pkg::*;
#(
    parameter int WIDTH = 32
)(
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic [31:0]           instr_i,
    input  logic                  instr_valid_i,
    input  logic                  flush_i,
    output logic                  result_valid_o,
    output logic [REG_ADDR_W-1:0] result_rd_o,
    output logic [WIDTH-1:0]      result_data_o
);

    // decode side
    logic [REG_ADDR_W-1:0] rs1_d, rs2_d, rd_d;
    logic [WIDTH-1:0]      imm_ext_d, rd_data1_d, rd_data2_d;
    alu_op_e               alu_ctrl_d;
    logic                  alu_src_d, reg_wr_en_d;

    // execute side
    logic [REG_ADDR_W-1:0] rs1_e, rs2_e, rd_e;
    logic [WIDTH-1:0]      imm_ext_e, rd_data1_e, rd_data2_e;
    alu_op_e               alu_ctrl_e;
    logic                  alu_src_e, reg_wr_en_e;

    // writeback
    logic                  wb_en;
    logic [REG_ADDR_W-1:0] wb_addr;
    logic [WIDTH-1:0]      wb_data;

    instr_decoder #(.WIDTH(WIDTH)) u_decoder (
        .instr_i(instr_i), .rs1_o(rs1_d), .rs2_o(rs2_d), .rd_o(rd_d),
        .imm_ext_o(imm_ext_d), .alu_op_o(alu_ctrl_d), .alu_src_o(alu_src_d),
        .reg_wr_en_o(reg_wr_en_d)
    );

    reg_file #(.WIDTH(WIDTH)) u_reg_file (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .rd_addr1_i(rs1_d), .rd_addr2_i(rs2_d),
        .rd_data1_o(rd_data1_d), .rd_data2_o(rd_data2_d),
        .wr_en_i(wb_en), .wr_addr_i(wb_addr), .wr_data_i(wb_data)
    );

    pipeline_reg_d_e #(.WIDTH(WIDTH)) u_pipe_d_e (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .flush_i(flush_i), .valid_i(instr_valid_i),
        .reg_wr_en_d_i(reg_wr_en_d), .alu_op_d_i(alu_ctrl_d), .alu_src_d_i(alu_src_d),
        .reg_wr_en_e_o(reg_wr_en_e), .alu_op_e_o(alu_ctrl_e), .alu_src_e_o(alu_src_e),
        .rd_data1_d_i(rd_data1_d), .rd_data2_d_i(rd_data2_d),
        .rd_addr1_d_i(rs1_d), .rd_addr2_d_i(rs2_d), .wr_addr_d_i(rd_d),
        .imm_ext_d_i(imm_ext_d),
        .rd_data1_e_o(rd_data1_e), .rd_data2_e_o(rd_data2_e),
        .rd_addr1_e_o(rs1_e), .rd_addr2_e_o(rs2_e), .wr_addr_e_o(rd_e),
        .imm_ext_e_o(imm_ext_e)
    );

    execute_stage #(.WIDTH(WIDTH)) u_execute (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .reg_wr_en_e_i(reg_wr_en_e), .alu_op_e_i(alu_ctrl_e), .alu_src_e_i(alu_src_e),
        .rd_data1_e_i(rd_data1_e), .rd_data2_e_i(rd_data2_e),
        .rd_addr1_e_i(rs1_e), .rd_addr2_e_i(rs2_e), .wr_addr_e_i(rd_e),
        .imm_ext_e_i(imm_ext_e),
        .wb_en_o(wb_en), .wb_addr_o(wb_addr), .wb_data_o(wb_data)
    );

    assign result_valid_o = wb_en;
    assign result_rd_o    = wb_addr;
    assign result_data_o  = wb_data;

endmodule

//--- testbench/tb_clk_gen.sv
module tb_clk_gen (
    output logic clk_o,
    output logic arst_n_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 4;

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;   // 20 ns period
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;
    end

endmodule

//--- testbench/tb_rv_slice.sv
module tb_rv_slice
    import rv_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          CLK_PERIOD = 20;
    localparam int          NUM_RANDOM = 400;
    localparam int          NUM_SLOTS  = NUM_RANDOM + 14;   // random plus directed
    localparam int          TIMEOUT_NS = (NUM_SLOTS * 20 + 100) * CLK_PERIOD;
    localparam logic [31:0] LFSR_SEED  = 32'h8456;
    localparam logic [31:0] LFSR_TAPS  = 32'h80200003;

    logic        clk;
    logic        arst_n;
    logic [31:0] instr_i;
    logic        instr_valid_i;
    logic        flush_i;
    logic        result_valid_o;
    logic [4:0]  result_rd_o;
    logic [31:0] result_data_o;

    logic [31:0] lfsr_state;
    logic [31:0] model_regs [32];
    string       exp_name_q [$];
    logic [4:0]  exp_rd_q [$];
    logic [31:0] exp_data_q [$];
    time         exp_time_q [$];

    string reg_names [8] = '{"add", "sll", "slt", "sltu", "xor", "srl", "or", "and"};
    string imm_names [8] = '{"addi", "slli", "slti", "sltiu", "xori", "srli", "ori", "andi"};

    tb_clk_gen u_clk_gen (.clk_o(clk), .arst_n_o(arst_n));

    rv_slice_top #(.WIDTH(32)) u_dut (
        .clk_i(clk), .arst_n_i(arst_n),
        .instr_i(instr_i), .instr_valid_i(instr_valid_i), .flush_i(flush_i),
        .result_valid_o(result_valid_o), .result_rd_o(result_rd_o),
        .result_data_o(result_data_o)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [11:0] pick_imm();
        logic [2:0] sel;
        sel = 3'(take_bits(3));
        case (sel)
            3'd0:    return 12'h800;   // most negative
            3'd1:    return 12'h7ff;
            3'd2:    return 12'hfff;
            default: return 12'(take_bits(12));
        endcase
    endfunction

    function automatic logic [31:0] reg_instr(input logic [2:0] f3, input logic alt,
                                              input logic [4:0] rd, rs1, rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] imm_instr(input logic [2:0] f3, input logic [11:0] imm,
                                              input logic [4:0] rd, rs1);
        return {imm, rs1, f3, rd, OP_IMM};
    endfunction

    function automatic logic [31:0] lui_instr(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OP_LUI};
    endfunction

    // rv32i semantics on the model registers
    function automatic logic [31:0] model_result(input logic [31:0] instr);
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  f3;
        logic        alt;
        f3  = instr[14:12];
        a   = model_regs[instr[19:15]];
        b   = (instr[6:0] == OP_REG) ? model_regs[instr[24:20]]
                                     : {{20{instr[31]}}, instr[31:20]};
        alt = instr[30] && (instr[6:0] == OP_REG || f3 == 3'b101);
        if (instr[6:0] == OP_LUI)
            return {instr[31:12], 12'h000};
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
            fail_run($sformatf("[ERROR] %s: expected %h, actual %h", name, expected, actual));
    endtask

    task automatic issue(input logic [31:0] instr, input string name,
                         input logic valid, input logic flush);
        logic [4:0]  rd;
        logic [31:0] data;
        rd = instr[11:7];
        @(negedge clk);
        instr_i       = instr;
        instr_valid_i = valid;
        flush_i       = flush;
        if (valid && !flush && rd != 5'd0) begin
            data = model_result(instr);
            model_regs[rd] = data;
            exp_name_q.push_back(name);
            exp_rd_q.push_back(rd);
            exp_data_q.push_back(data);
            exp_time_q.push_back($time + 2 * CLK_PERIOD);   // two edges later
        end
    endtask

    task automatic directed_sequence();
        issue(lui_instr(20'h80000, 5'd1), "lui x1", 1'b1, 1'b0);
        issue(imm_instr(3'b000, 12'hfff, 5'd2, 5'd0), "addi x2 -1", 1'b1, 1'b0);
        issue(reg_instr(3'b010, 1'b0, 5'd3, 5'd2, 5'd0), "slt edge", 1'b1, 1'b0);
        issue(reg_instr(3'b011, 1'b0, 5'd4, 5'd2, 5'd0), "sltu edge", 1'b1, 1'b0);
        issue(reg_instr(3'b000, 1'b1, 5'd5, 5'd1, 5'd3), "sub fwd", 1'b1, 1'b0);
        issue(reg_instr(3'b101, 1'b1, 5'd6, 5'd1, 5'd2), "sra by 31", 1'b1, 1'b0);
        issue(imm_instr(3'b101, 12'h404, 5'd7, 5'd1), "srai 4", 1'b1, 1'b0);
        issue(imm_instr(3'b001, 12'h001, 5'd7, 5'd7), "slli fwd", 1'b1, 1'b0);
        issue(imm_instr(3'b000, 12'h001, 5'd0, 5'd5), "addi x0", 1'b1, 1'b0);
        issue(reg_instr(3'b000, 1'b0, 5'd3, 5'd0, 5'd5), "add from x0", 1'b1, 1'b0);
        issue(imm_instr(3'b000, 12'h000, 5'd5, 5'd0), "flushed", 1'b1, 1'b1);
        issue(imm_instr(3'b000, 12'h000, 5'd5, 5'd0), "invalid", 1'b0, 1'b0);
        issue(imm_instr(3'b011, 12'hfff, 5'd4, 5'd5), "sltiu -1", 1'b1, 1'b0);
        issue(imm_instr(3'b100, 12'h800, 5'd6, 5'd5), "xori neg", 1'b1, 1'b0);
    endtask

    task automatic random_slot(input int idx);
        logic [3:0]  ctl;
        logic [1:0]  cls;
        logic [2:0]  f3;
        logic        alt;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [31:0] instr;
        string       mnem;
        ctl = 4'(take_bits(4));   // 0 invalid, 1 flush
        cls = 2'(take_bits(2));
        f3  = 3'(take_bits(3));
        alt = 1'(take_bits(1));
        rd  = 5'(take_bits(3));   // x0..x7 keeps dependencies close
        rs1 = 5'(take_bits(3));
        rs2 = 5'(take_bits(3));
        imm = pick_imm();
        if (cls == 2'd3) begin
            instr = lui_instr(take_bits(2) == 0 ? 20'h80000 : 20'(take_bits(20)), rd);
            mnem  = "lui";
        end else if (cls == 2'd2) begin
            alt = alt && (f3 == 3'b101);
            if (f3 == 3'b001 || f3 == 3'b101)
                imm = {1'b0, alt, 5'b0, imm[4:0]};
            instr = imm_instr(f3, imm, rd, rs1);
            mnem  = alt ? "srai" : imm_names[f3];
        end else begin
            alt   = alt && (f3 == 3'b000 || f3 == 3'b101);
            instr = reg_instr(f3, alt, rd, rs1, rs2);
            mnem  = alt ? ((f3 == 3'b000) ? "sub" : "sra") : reg_names[f3];
        end
        issue(instr, $sformatf("#%0d %s", idx, mnem), ctl != 4'd0, ctl == 4'd1);
    endtask

    initial begin
        instr_i       = '0;
        instr_valid_i = 1'b0;
        flush_i       = 1'b0;
        lfsr_state    = LFSR_SEED;
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        @(posedge arst_n);
        directed_sequence();
        for (int i = 0; i < NUM_RANDOM; i++)
            random_slot(i);
        issue(32'h0, "idle", 1'b0, 1'b0);
        repeat (4) @(negedge clk);   // drain the two stages
        if (exp_rd_q.size() != 0) begin
            fail_run($sformatf("%0d expected results never appeared", exp_rd_q.size()));
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

    // compare on the falling edge, outputs are settled
    initial begin : compare
        string name;
        time   due;
        forever begin
            @(negedge clk);
            if (result_valid_o === 1'b1) begin
                if (exp_rd_q.size() == 0) begin
                    fail_run("result_valid_o was high with no result expected");
                end else begin
                    name = exp_name_q.pop_front();
                    due  = exp_time_q.pop_front();
                    check_value({name, " latency"}, 32'(due), 32'($time));
                    check_value({name, " rd"}, 32'(exp_rd_q.pop_front()), 32'(result_rd_o));
                    check_value({name, " data"}, exp_data_q.pop_front(), result_data_o);
                end
            end else if (result_valid_o !== 1'b0) begin
                fail_run("result_valid_o is unknown");
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        fail_run("timeout, the run did not finish in time");
    end

endmodule
